// File: files.f
verilog/ising_cfg_pkg.sv
verilog/ising_mem_pkg.sv
verilog/flip_raddr_gen.sv
verilog/flip_filter.sv
verilog/weight_mem_arbiter.sv
verilog/weight_mem.sv
verilog/ising_flip_top.sv
sim/tb_ising_flip_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the spin-flip front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f files.f \
    --top-module tb_ising_flip_top \
    --Mdir obj_dir -o tb_sim

# the simulation result is taken from the log, not from the exit status
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: sim/tb_ising_flip_top.sv
// ============================
// stimulus table, host loading, reference model and checks
// ============================

module tb_ising_flip_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 60;

    typedef struct packed {
        ising_cfg_pkg::spin_vec_t   spin;
        ising_cfg_pkg::spin_vec_t   base;
        logic                       det;
        ising_cfg_pkg::block_addr_t bound;
        logic                       dsr;
        logic                       host;
        logic                       flush;
    } entry_t;

    logic                       clk_i;
    logic                       arst_n_i;
    logic                       en_i;
    logic                       flush_i;
    logic                       flip_detect_en_i;
    ising_cfg_pkg::block_addr_t bound_i;
    logic                       spin_valid_i;
    logic                       spin_ready_o;
    ising_cfg_pkg::spin_item_t  spin_item_i;
    logic                       spin_valid_o;
    logic                       spin_ready_i;
    ising_cfg_pkg::spin_vec_t   spin_o;
    logic                       baseline_valid_o;
    logic                       empty_o;
    logic                       host_wr_valid_i;
    logic                       host_wr_ready_o;
    ising_mem_pkg::wmem_req_t   host_wr_i;
    logic                       wt_valid_o;
    ising_mem_pkg::wmem_rsp_t   wt_o;

    ising_mem_pkg::weight_row_t rows [ising_cfg_pkg::NUM_BLOCK];
    ising_mem_pkg::wmem_rsp_t   rsp_q[$];
    ising_cfg_pkg::spin_vec_t   dn_q[$];
    logic                       base_ok;
    integer                     seed;

    // spin, baseline, detect, bound, downstream ready, host writes, flush
    entry_t table_q [10] = '{
        '{16'hA5C3, 16'h0000, 1'b1, 2'd3, 1'b1, 1'b0, 1'b0},
        '{16'h1234, 16'h0274, 1'b1, 2'd3, 1'b1, 1'b0, 1'b0},
        '{16'h5A5A, 16'h5A5A, 1'b1, 2'd3, 1'b1, 1'b0, 1'b0},
        '{16'hFFFF, 16'h0000, 1'b1, 2'd1, 1'b1, 1'b0, 1'b0},
        '{16'h0001, 16'h0001, 1'b0, 2'd2, 1'b1, 1'b0, 1'b0},
        '{16'h0F0F, 16'h0000, 1'b1, 2'd3, 1'b1, 1'b1, 1'b0},
        '{16'h3C3C, 16'h3C3C, 1'b0, 2'd3, 1'b1, 1'b0, 1'b0},
        '{16'h00F0, 16'h0000, 1'b1, 2'd3, 1'b0, 1'b0, 1'b0},
        '{16'hFFFF, 16'h0000, 1'b1, 2'd3, 1'b1, 1'b0, 1'b1},
        '{16'h0010, 16'h0010, 1'b1, 2'd3, 1'b1, 1'b0, 1'b0}
    };

    ising_flip_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // weight responses and downstream spins in arrival order
    always @(negedge clk_i) begin
        if (wt_valid_o) rsp_q.push_back(wt_o);
        if (spin_valid_o) dn_q.push_back(spin_o);
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            fail_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, act, exp));
        end
    endtask

    task automatic write_row(input ising_cfg_pkg::block_addr_t addr,
                             input ising_mem_pkg::weight_row_t data);
        int n;
        n = 0;
        @(posedge clk_i);
        host_wr_valid_i <= 1'b1;
        host_wr_i <= '{write: 1'b1, addr: addr, data: data, mask: '0, last: 1'b0};
        @(negedge clk_i);
        while (!host_wr_ready_o) begin
            n++;
            if (n > TIMEOUT) fail_run("host write was never accepted");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        host_wr_valid_i <= 1'b0;
        rows[addr] = data;
    endtask

    task automatic wait_rsp(input int count);
        int n;
        n = 0;
        while (rsp_q.size() < count) begin
            n++;
            if (n > TIMEOUT) fail_run("weight responses did not all arrive");
            @(negedge clk_i);
        end
    endtask

    // flips per the filter rule, only blocks 0 to bound kept
    function automatic ising_cfg_pkg::spin_vec_t expected_mask(input entry_t e);
        ising_cfg_pkg::spin_vec_t m;
        ising_cfg_pkg::spin_vec_t keep;
        m = (e.det && base_ok) ? (e.spin ^ e.base) : '1;
        keep = '1;
        keep = keep >> (4 * (3 - int'(e.bound)));
        return m & keep;
    endfunction

    task automatic apply_entry(input entry_t e);
        ising_cfg_pkg::spin_vec_t m;
        ising_mem_pkg::wmem_rsp_t exp_q[$];
        ising_mem_pkg::wmem_rsp_t r;
        int n;
        m = expected_mask(e);
        for (int b = 0; b < 4; b++) begin
            if (m[b*4 +: 4] != '0) begin
                r.addr = ising_cfg_pkg::block_addr_t'(b);
                r.mask = m[b*4 +: 4];
                r.data = rows[b];
                r.last = (m >> (4 * (b + 1))) == '0;
                exp_q.push_back(r);
            end
        end
        rsp_q.delete();
        dn_q.delete();
        @(posedge clk_i);
        spin_item_i <= '{spin: e.spin, baseline: e.base};
        flip_detect_en_i <= e.det;
        bound_i <= e.bound;
        spin_valid_i <= 1'b1;
        spin_ready_i <= e.dsr;
        if (!e.dsr) begin
            repeat (3) begin
                @(negedge clk_i);
                compare("spin_ready_o", 64'(spin_ready_o), 64'(0));
            end
            @(posedge clk_i);
            spin_ready_i <= 1'b1;
        end
        n = 0;
        @(negedge clk_i);
        while (!spin_ready_o) begin
            n++;
            if (n > TIMEOUT) fail_run("spin item was never accepted");
            @(negedge clk_i);
        end
        compare("empty_o", 64'(empty_o), 64'(exp_q.size() == 0));
        @(posedge clk_i);
        spin_valid_i <= 1'b0;
        compare("spin_valid_o count", 64'(dn_q.size()), 64'(exp_q.size() > 0));
        if (dn_q.size() > 0) compare("spin_o", 64'(dn_q[0]), 64'(e.spin));
        if (e.flush) begin
            flush_i <= 1'b1;
            @(posedge clk_i);
            flush_i <= 1'b0;
            @(negedge clk_i);
            compare("baseline_valid_o", 64'(baseline_valid_o), 64'(0));
            base_ok = 1'b0;
            // let reads in flight drain
            repeat (4) @(negedge clk_i);
            // only the read accepted in the flush cycle comes back
            compare("wt_valid_o count", 64'(rsp_q.size()), 64'(1));
            rsp_q.delete();
        end else begin
            if (e.host) begin
                fork
                    begin
                        write_row(2'd1, $random(seed));
                        write_row(2'd3, $random(seed));
                    end
                    wait_rsp(exp_q.size());
                join
            end else begin
                wait_rsp(exp_q.size());
            end
            repeat (3) @(negedge clk_i);
            compare("wt_valid_o count", 64'(rsp_q.size()), 64'(exp_q.size()));
            for (int i = 0; i < exp_q.size(); i++) begin
                compare("wt_o.addr", 64'(rsp_q[i].addr), 64'(exp_q[i].addr));
                compare("wt_o.mask", 64'(rsp_q[i].mask), 64'(exp_q[i].mask));
                compare("wt_o.data", 64'(rsp_q[i].data), 64'(exp_q[i].data));
                compare("wt_o.last", 64'(rsp_q[i].last), 64'(exp_q[i].last));
            end
            base_ok = 1'b1;
            compare("baseline_valid_o", 64'(baseline_valid_o), 64'(1));
        end
    endtask

    initial begin
        seed = 66;
        base_ok = 1'b0;
        arst_n_i = 1'b0;
        en_i = 1'b1;
        flush_i = 1'b0;
        flip_detect_en_i = 1'b0;
        bound_i = '0;
        spin_valid_i = 1'b0;
        spin_item_i = '0;
        spin_ready_i = 1'b1;
        host_wr_valid_i = 1'b0;
        host_wr_i = '0;
        repeat (5) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        compare("spin_valid_o", 64'(spin_valid_o), 64'(0));
        compare("wt_valid_o", 64'(wt_valid_o), 64'(0));
        compare("host_wr_ready_o", 64'(host_wr_ready_o), 64'(0));
        compare("baseline_valid_o", 64'(baseline_valid_o), 64'(0));
        compare("spin_ready_o", 64'(spin_ready_o), 64'(1));
        for (int b = 0; b < 4; b++) begin
            write_row(ising_cfg_pkg::block_addr_t'(b), $random(seed));
        end
        for (int i = 0; i < 10; i++) begin
            apply_entry(table_q[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog/ising_flip_top.sv
// ============================
// spin-flip front end top level
// ============================

module ising_flip_top (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       en_i,
    input  logic                       flush_i,
    input  logic                       flip_detect_en_i,
    input  ising_cfg_pkg::block_addr_t bound_i,

    input  logic                       spin_valid_i,
    output logic                       spin_ready_o,
    input  ising_cfg_pkg::spin_item_t  spin_item_i,

    output logic                       spin_valid_o,
    input  logic                       spin_ready_i,
    output ising_cfg_pkg::spin_vec_t   spin_o,

    output logic                       baseline_valid_o,
    output logic                       empty_o,

    input  logic                       host_wr_valid_i,
    output logic                       host_wr_ready_o,
    input  ising_mem_pkg::wmem_req_t   host_wr_i,

    output logic                       wt_valid_o,
    output ising_mem_pkg::wmem_rsp_t   wt_o
);

    logic                     rd_valid;
    logic                     rd_ready;
    ising_mem_pkg::wmem_req_t rd_req;
    logic                     mem_valid;
    ising_mem_pkg::wmem_req_t mem_req;

    flip_filter u_filter (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .en_i             (en_i),
        .flush_i          (flush_i),
        .flip_detect_en_i (flip_detect_en_i),
        .bound_i          (bound_i),
        .spin_valid_i     (spin_valid_i),
        .spin_ready_o     (spin_ready_o),
        .spin_item_i      (spin_item_i),
        .spin_valid_o     (spin_valid_o),
        .spin_ready_i     (spin_ready_i),
        .spin_o           (spin_o),
        .baseline_valid_o (baseline_valid_o),
        .rd_valid_o       (rd_valid),
        .rd_ready_i       (rd_ready),
        .rd_req_o         (rd_req),
        .empty_o          (empty_o)
    );

    weight_mem_arbiter u_arbiter (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .host_valid_i (host_wr_valid_i),
        .host_ready_o (host_wr_ready_o),
        .host_req_i   (host_wr_i),
        .filt_valid_i (rd_valid),
        .filt_ready_o (rd_ready),
        .filt_req_i   (rd_req),
        .mem_valid_o  (mem_valid),
        .mem_req_o    (mem_req)
    );

    weight_mem u_mem (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (mem_valid),
        .req_i       (mem_req),
        .rsp_valid_o (wt_valid_o),
        .rsp_o       (wt_o)
    );

endmodule

// File: verilog/weight_mem.sv
// ============================
// single-port weight rows, registered read
// ============================

module weight_mem (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     req_valid_i,
    input  ising_mem_pkg::wmem_req_t req_i,
    output logic                     rsp_valid_o,
    output ising_mem_pkg::wmem_rsp_t rsp_o
);

    ising_mem_pkg::weight_row_t rows [ising_cfg_pkg::NUM_BLOCK];

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_i.write) begin
            rows[req_i.addr] <= req_i.data;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i & ~req_i.write;
        end
    end

    // read tag follows the request
    always_ff @(posedge clk_i) begin
        if (req_valid_i && !req_i.write) begin
            rsp_o.addr <= req_i.addr;
            rsp_o.mask <= req_i.mask;
            rsp_o.last <= req_i.last;
            rsp_o.data <= rows[req_i.addr];
        end
    end

endmodule

// File: verilog/weight_mem_arbiter.sv
// ============================
// round-robin host/filter arbiter
// ============================

module weight_mem_arbiter (
    input  logic                     clk_i,
    input  logic                     arst_n_i,

    input  logic                     host_valid_i,
    output logic                     host_ready_o,
    input  ising_mem_pkg::wmem_req_t host_req_i,

    input  logic                     filt_valid_i,
    output logic                     filt_ready_o,
    input  ising_mem_pkg::wmem_req_t filt_req_i,

    output logic                     mem_valid_o,
    output ising_mem_pkg::wmem_req_t mem_req_o
);

    ising_mem_pkg::arb_grant_e prio_q;
    logic                      contend;

    assign contend = host_valid_i & filt_valid_i;

    // priority owner takes the port on a conflict
    assign host_ready_o = host_valid_i &
                          (~filt_valid_i | (prio_q == ising_mem_pkg::GRANT_HOST));
    assign filt_ready_o = filt_valid_i &
                          (~host_valid_i | (prio_q == ising_mem_pkg::GRANT_FILTER));

    assign mem_valid_o = host_valid_i | filt_valid_i;
    assign mem_req_o = host_ready_o ? host_req_i : filt_req_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_q <= ising_mem_pkg::GRANT_HOST;
        end else if (contend) begin
            // winner drops to low priority
            if (prio_q == ising_mem_pkg::GRANT_HOST) begin
                prio_q <= ising_mem_pkg::GRANT_FILTER;
            end else begin
                prio_q <= ising_mem_pkg::GRANT_HOST;
            end
        end
    end

endmodule

// File: verilog/flip_filter.sv
// ============================
// flip filter: spin compare, scan control, handshakes
// ============================

module flip_filter (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        en_i,
    input  logic                        flush_i,
    input  logic                        flip_detect_en_i,
    input  ising_cfg_pkg::block_addr_t  bound_i,

    // upstream
    input  logic                        spin_valid_i,
    output logic                        spin_ready_o,
    input  ising_cfg_pkg::spin_item_t   spin_item_i,

    // downstream
    output logic                        spin_valid_o,
    input  logic                        spin_ready_i,
    output ising_cfg_pkg::spin_vec_t    spin_o,

    output logic                        baseline_valid_o,

    // weight read requests
    output logic                        rd_valid_o,
    input  logic                        rd_ready_i,
    output ising_mem_pkg::wmem_req_t    rd_req_o,

    output logic                        empty_o
);

    localparam int unsigned P = ising_cfg_pkg::PARALLELISM;

    logic                     busy_q;
    logic                     baseline_q;
    logic                     up_hs;
    logic                     scan_load;
    logic                     last_hs;
    ising_cfg_pkg::spin_vec_t flip_raw;
    ising_cfg_pkg::spin_vec_t flip_mask;

    assign spin_ready_o = en_i & ~busy_q & spin_ready_i;
    assign up_hs = spin_valid_i & spin_ready_o;

    // no usable baseline means every spin counts as flipped
    always_comb begin
        if (flip_detect_en_i && baseline_q) begin
            flip_raw = spin_item_i.spin ^ spin_item_i.baseline;
        end else begin
            flip_raw = '1;
        end
    end

    // blocks above the bound are never read
    always_comb begin
        flip_mask = flip_raw;
        for (int b = 0; b < ising_cfg_pkg::NUM_BLOCK; b++) begin
            if (b > int'(bound_i)) begin
                flip_mask[b*P +: P] = '0;
            end
        end
    end

    assign empty_o = ~|flip_mask;
    assign scan_load = up_hs & ~empty_o;

    assign spin_valid_o = scan_load;
    assign spin_o = spin_item_i.spin;
    assign baseline_valid_o = baseline_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
        end else if (scan_load) begin
            busy_q <= 1'b1;
        end else if (last_hs) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            baseline_q <= 1'b0;
        end else if (flush_i) begin
            baseline_q <= 1'b0;
        end else if (last_hs || (up_hs && empty_o)) begin
            baseline_q <= 1'b1;
        end
    end

    flip_raddr_gen u_raddr_gen (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .load_i      (scan_load),
        .mask_i      (flip_mask),
        .req_valid_o (rd_valid_o),
        .req_ready_i (rd_ready_i),
        .req_o       (rd_req_o),
        .last_hs_o   (last_hs)
    );

endmodule

// File: verilog/flip_raddr_gen.sv
// ============================
// flipped block scanner, one read address per block
// ============================

module flip_raddr_gen (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     flush_i,
    input  logic                     load_i,
    input  ising_cfg_pkg::spin_vec_t mask_i,
    output logic                     req_valid_o,
    input  logic                     req_ready_i,
    output ising_mem_pkg::wmem_req_t req_o,
    output logic                     last_hs_o
);

    localparam int unsigned P = ising_cfg_pkg::PARALLELISM;

    ising_cfg_pkg::spin_vec_t          mask_q;
    logic [ising_cfg_pkg::NUM_BLOCK-1:0] blk_nz;
    logic [ising_cfg_pkg::NUM_BLOCK-1:0] others_nz;
    ising_cfg_pkg::block_addr_t        sel_idx;
    logic                              sel_found;
    logic                              req_hs;

    // blocks still holding flipped spins
    always_comb begin
        for (int b = 0; b < ising_cfg_pkg::NUM_BLOCK; b++) begin
            blk_nz[b] = |mask_q[b*P +: P];
        end
    end

    // lowest pending block wins
    always_comb begin
        sel_idx = '0;
        sel_found = 1'b0;
        for (int b = 0; b < ising_cfg_pkg::NUM_BLOCK; b++) begin
            if (blk_nz[b] && !sel_found) begin
                sel_idx = ising_cfg_pkg::block_addr_t'(b);
                sel_found = 1'b1;
            end
        end
    end

    always_comb begin
        others_nz = blk_nz;
        others_nz[sel_idx] = 1'b0;
    end

    assign req_valid_o = sel_found;
    assign req_hs = req_valid_o & req_ready_i;

    always_comb begin
        req_o = '0;
        req_o.write = 1'b0;
        req_o.addr = sel_idx;
        req_o.mask = mask_q[sel_idx*P +: P];
        req_o.last = ~|others_nz;
    end

    assign last_hs_o = req_hs & req_o.last;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_q <= '0;
        end else if (flush_i) begin
            mask_q <= '0;
        end else if (load_i) begin
            mask_q <= mask_i;
        end else if (req_hs) begin
            // served block drops out of the scan
            mask_q[sel_idx*P +: P] <= '0;
        end
    end

endmodule

// File: verilog/ising_mem_pkg.sv
// ============================
// weight memory widths, bus structs, grant enum
// ============================

package ising_mem_pkg;

    localparam int unsigned WEIGHT_W = 32;

    typedef logic [WEIGHT_W-1:0] weight_row_t;

    typedef struct packed {
        logic                       write;
        ising_cfg_pkg::block_addr_t addr;
        weight_row_t                data;
        ising_cfg_pkg::block_mask_t mask;
        logic                       last;
    } wmem_req_t;

    typedef struct packed {
        ising_cfg_pkg::block_addr_t addr;
        ising_cfg_pkg::block_mask_t mask;
        logic                       last;
        weight_row_t                data;
    } wmem_rsp_t;

    typedef enum logic {
        GRANT_HOST,
        GRANT_FILTER
    } arb_grant_e;

endpackage

// File: verilog/ising_cfg_pkg.sv
// ============================
// spin array sizes, spin typedefs, upstream item struct
// ============================

package ising_cfg_pkg;

    localparam int unsigned NUM_SPIN = 16;
    localparam int unsigned PARALLELISM = 4;
    localparam int unsigned NUM_BLOCK = NUM_SPIN / PARALLELISM;
    localparam int unsigned BLOCK_ADDR_W = 2;

    typedef logic [NUM_SPIN-1:0] spin_vec_t;
    typedef logic [PARALLELISM-1:0] block_mask_t;
    typedef logic [BLOCK_ADDR_W-1:0] block_addr_t;

    // upstream payload
    typedef struct packed {
        spin_vec_t spin;
        spin_vec_t baseline;
    } spin_item_t;

endpackage
